// File: tb.f
+incdir+verilog
+incdir+verification
verilog/ctrlPkg.sv
verilog/rTypeDecoder.sv
verilog/iTypeDecoder.sv
verilog/ctrlStage.sv
verilog/controlUnit.sv
verification/tbControlUnit.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
        -f tb.f --top-module tbControlUnit -o simv \
        || { echo "build failed"; exit 1; }

simOut="$(./obj_dir/simv)"
echo "$simOut"
echo "$simOut" | grep -q "ALL CHECKS PASSED" && exit 0 || { echo "simulation failed"; exit 1; }

// File: verification/refDecode.svh
`ifndef REF_DECODE_SVH
`define REF_DECODE_SVH

// one 32-bit xorshift step
function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
endfunction

function automatic ctrlBundle refDecode(input instrWord w, input logic irqIn,
                input logic kernelIn);
        ctrlBundle b;
        logic known;
        logic [5:0] op;
        logic [5:0] fn;
        b = '0;
        known = 1'b1;
        op = w.rFields.op;
        fn = w.rFields.funct;
        if (op == 6'h00) begin
                b.regWr = 1'b1; // all but jr write rd
                case (fn)
                        6'h20: b.sign = 1'b1;
                        6'h21: b.sign = 1'b0;
                        6'h22: begin
                                b.aluFun = aluSub;
                                b.sign = 1'b1;
                        end
                        6'h23: b.aluFun = aluSub;
                        6'h24: b.aluFun = aluAnd;
                        6'h25: b.aluFun = aluOr;
                        6'h26: b.aluFun = aluXor;
                        6'h27: b.aluFun = aluNor;
                        6'h2a: begin
                                b.aluFun = aluLt;
                                b.sign = 1'b1;
                        end
                        6'h00: begin
                                b.aluSrc1 = 1'b1;
                                b.aluFun = aluSll;
                        end
                        6'h02: begin
                                b.aluSrc1 = 1'b1;
                                b.aluFun = aluSrl;
                        end
                        6'h03: begin
                                b.aluSrc1 = 1'b1;
                                b.aluFun = aluSra;
                        end
                        6'h08: begin
                                b.regWr = 1'b0;
                                b.pcSrc = pcReg;
                        end
                        6'h09: begin
                                b.pcSrc = pcReg;
                                b.memToReg = wbLink;
                        end
                        default: known = 1'b0;
                endcase
        end else begin
                case (op)
                        6'h23, 6'h2b, 6'h08, 6'h09, 6'h0a, 6'h0b: begin
                                b.aluSrc2 = 1'b1;
                                b.extOp = 1'b1;
                                b.regWr = (op != 6'h2b);
                                b.regDst = (op == 6'h2b) ? dstRd : dstRt;
                                b.memWr = (op == 6'h2b);
                                b.memRd = (op == 6'h23);
                                b.memToReg = (op == 6'h23) ? wbMem : wbAlu;
                                b.sign = (op == 6'h08) || (op == 6'h0a);
                                b.aluFun = (op == 6'h0a || op == 6'h0b) ? aluLt : aluAdd;
                        end
                        6'h0c, 6'h0f: begin
                                b.regWr = 1'b1;
                                b.regDst = dstRt;
                                b.aluSrc2 = 1'b1;
                                b.luOp = (op == 6'h0f);
                                b.aluFun = (op == 6'h0c) ? aluAnd : aluAdd;
                        end
                        6'h04, 6'h05, 6'h06, 6'h07, 6'h01: begin
                                b.pcSrc = pcBranch;
                                b.extOp = 1'b1;
                                case (op)
                                        6'h04: b.aluFun = aluEq;
                                        6'h05: b.aluFun = aluNeq;
                                        6'h06: b.aluFun = aluLez;
                                        6'h07: b.aluFun = aluGtz;
                                        default: b.aluFun = aluLtz;
                                endcase
                        end
                        6'h02: b.pcSrc = pcJump;
                        6'h03: begin
                                b.pcSrc = pcJump;
                                b.regWr = 1'b1;
                                b.regDst = dstRa;
                                b.memToReg = wbLink;
                        end
                        default: known = 1'b0;
                endcase
        end
        if (irqIn && !kernelIn) begin
                b = '0;
                b.pcSrc = pcIrq;
                b.regWr = 1'b1;
                b.regDst = dstXp;
                b.memToReg = wbIrqLink;
        end else if (!known) begin
                b = '0; // kernel no-op
                if (!kernelIn) begin
                        b.pcSrc = pcExc;
                        b.regWr = 1'b1;
                        b.regDst = dstXp;
                        b.memToReg = wbLink;
                end
        end
        return b;
endfunction

`endif

// File: verification/tbControlUnit.sv
module tbControlUnit;

        timeunit 1ns;
        timeprecision 100ps;

        import ctrlPkg::*;

        `include "refDecode.svh"

        localparam logic [5:0] rFunctList [14] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24,
                6'h25, 6'h26, 6'h27, 6'h00, 6'h02, 6'h03, 6'h2a, 6'h08, 6'h09};
        localparam logic [5:0] iOpList [15] = '{6'h23, 6'h2b, 6'h0f, 6'h08, 6'h09,
                6'h0c, 6'h0a, 6'h0b, 6'h04, 6'h05, 6'h06, 6'h07, 6'h01, 6'h02, 6'h03};

        logic clk;
        logic rst;
        instrWord instr;
        logic instrValid;
        logic irq;
        logic kernelMode;
        ctrlBundle ctrl;
        logic ctrlValid;

        ctrlBundle expCtrl;
        logic expValid;
        logic expArmed; // set after the first edge
        string testName;
        string expName;
        logic [31:0] rngState;
        int checkCount;
        int ctrlErrors;
        int validErrors;

        controlUnit u_dut (
                .clk(clk),
                .rst(rst),
                .instr(instr),
                .instrValid(instrValid),
                .irq(irq),
                .kernelMode(kernelMode),
                .ctrl(ctrl),
                .ctrlValid(ctrlValid)
        );

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        initial begin
                rst = 1'b1;
                repeat (8) @(posedge clk);
                #1;
                rst = 1'b0;
        end

        function automatic logic [31:0] nextRand();
                rngState = xorshift(rngState);
                return rngState;
        endfunction

        task automatic checkCtrl(input string name, input ctrlBundle expected,
                        input ctrlBundle actual);
                checkCount++;
                if (actual !== expected) begin
                        ctrlErrors++;
                        $display("Fail %s ctrl: expected %h actual %h at %0t",
                                name, expected, actual, $time);
                end
        endtask

        task automatic checkValid(input string name, input logic expected, input logic actual);
                checkCount++;
                if (actual !== expected) begin
                        validErrors++;
                        $display("Fail %s ctrlValid: expected %b actual %b at %0t",
                                name, expected, actual, $time);
                end
        endtask

        task automatic applyInstr(input string name, input logic [31:0] word, input logic valid,
                        input logic irqIn, input logic kernelIn);
                @(posedge clk);
                #1;
                testName = name;
                instr = word;
                instrValid = valid;
                irq = irqIn;
                kernelMode = kernelIn;
        endtask

        // expected value of the decode register after this edge
        always @(posedge clk) begin
                expArmed = 1'b1;
                expName = testName;
                if (rst) begin
                        expValid = 1'b0;
                        expCtrl = '0;
                end else begin
                        expValid = instrValid;
                        if (instrValid) begin
                                expCtrl = refDecode(instr, irq, kernelMode);
                        end
                end
        end

        always @(negedge clk) begin
                if (expArmed) begin
                        checkValid(expName, expValid, ctrlValid);
                        checkCtrl(expName, expCtrl, ctrl); // also covers hold on bubbles
                end
        end

        initial begin
                int waitCycles;
                int k;
                int idx;
                logic [31:0] r;
                logic [31:0] sel;
                logic [31:0] word;
                instr = '0;
                instrValid = 1'b0;
                irq = 1'b0;
                kernelMode = 1'b0;
                expArmed = 1'b0;
                testName = "reset";
                rngState = 32'h2ccc;
                checkCount = 0;
                ctrlErrors = 0;
                validErrors = 0;

                waitCycles = 0;
                while (rst !== 1'b0 && waitCycles < 50) begin
                        @(posedge clk);
                        waitCycles++;
                end
                if (rst !== 1'b0) begin
                        $display("timeout: the wait for reset release expired after 50 cycles");
                        $display("CHECKS FAILED");
                        $finish;
                end else begin
                        for (k = 0; k < 14; k++) begin
                                r = nextRand();
                                applyInstr("rType", {6'h00, r[25:6], rFunctList[k]}, 1'b1, 1'b0, 1'b0);
                        end
                        for (k = 0; k < 15; k++) begin
                                r = nextRand();
                                applyInstr("iType", {iOpList[k], r[25:0]}, 1'b1, 1'b0, 1'b0);
                        end
                        for (k = 0; k < 2; k++) begin // user mode, then kernel mode
                                r = nextRand();
                                applyInstr("badOp", {6'h3f, r[25:0]}, 1'b1, 1'b0, k[0]);
                                applyInstr("badOp", {6'h10, r[25:0]}, 1'b1, 1'b0, k[0]);
                                applyInstr("badFunct", {6'h00, r[25:6], 6'h01}, 1'b1, 1'b0, k[0]);
                                applyInstr("badFunct", {6'h00, r[25:6], 6'h3f}, 1'b1, 1'b0, k[0]);
                        end
                        for (k = 0; k < 6; k++) begin
                                r = nextRand();
                                applyInstr("irqUser", r, 1'b1, 1'b1, 1'b0);
                                applyInstr("irqKernel", {iOpList[k], r[25:0]}, 1'b1, 1'b1, 1'b1);
                        end
                        for (k = 0; k < 500; k++) begin
                                r = nextRand();
                                sel = nextRand();
                                case (sel[1:0])
                                        2'd0: begin
                                                idx = sel[15:8] % 14;
                                                word = {6'h00, r[25:6], rFunctList[idx]};
                                        end
                                        2'd1: begin
                                                idx = sel[15:8] % 15;
                                                word = {iOpList[idx], r[25:0]};
                                        end
                                        default: word = r; // mostly illegal ops
                                endcase
                                applyInstr("random", word, sel[19:16] != 4'h0,
                                        sel[23:20] == 4'h0, sel[24]);
                        end
                        applyInstr("drain", 32'h0, 1'b0, 1'b0, 1'b0);
                        repeat (2) @(posedge clk);
                        @(negedge clk);
                        $display("summary: %0d checks, %0d ctrl errors, %0d valid errors",
                                checkCount, ctrlErrors, validErrors);
                        if (ctrlErrors + validErrors == 0) begin
                                $display("ALL CHECKS PASSED");
                        end else begin
                                $display("CHECKS FAILED");
                        end
                        $finish;
                end
        end

endmodule

// File: verilog/controlUnit.sv
module controlUnit (
        input logic clk,
        input logic rst,
        input ctrlPkg::instrWord instr,
        input logic instrValid,
        input logic irq,
        input logic kernelMode,
        output ctrlPkg::ctrlBundle ctrl,
        output logic ctrlValid
);

        import ctrlPkg::*;

        ctrlBundle rCtrl;
        ctrlBundle iCtrl;
        logic rLegal;
        logic iLegal;

        rTypeDecoder u_rDec (
                .instr(instr),
                .ctrl(rCtrl),
                .legal(rLegal)
        );

        iTypeDecoder u_iDec (
                .instr(instr),
                .ctrl(iCtrl),
                .legal(iLegal)
        );

        ctrlStage u_stage (
                .clk(clk),
                .rst(rst),
                .instr(instr),
                .instrValid(instrValid),
                .irq(irq),
                .kernelMode(kernelMode),
                .rCtrl(rCtrl),
                .rLegal(rLegal),
                .iCtrl(iCtrl),
                .iLegal(iLegal),
                .ctrl(ctrl),
                .ctrlValid(ctrlValid)
        );

endmodule

// File: verilog/ctrlStage.sv
module ctrlStage (
        input logic clk,
        input logic rst,
        input ctrlPkg::instrWord instr,
        input logic instrValid,
        input logic irq,
        input logic kernelMode,
        input ctrlPkg::ctrlBundle rCtrl,
        input logic rLegal,
        input ctrlPkg::ctrlBundle iCtrl,
        input logic iLegal,
        output ctrlPkg::ctrlBundle ctrl,
        output logic ctrlValid
);

        import ctrlPkg::*;

        ctrlBundle selCtrl;
        ctrlBundle nextCtrl;
        logic selLegal;

        always_comb begin
                if (instr.rFields.op == '0) begin // special opcode, use funct table
                        selCtrl = rCtrl;
                        selLegal = rLegal;
                end else begin
                        selCtrl = iCtrl;
                        selLegal = iLegal;
                end
        end

        // interrupt beats everything, then illegal handling
        always_comb begin
                nextCtrl = selCtrl;
                if (!kernelMode && irq) begin
                        nextCtrl = '0;
                        nextCtrl.regWr = 1'b1;
                        nextCtrl.regDst = dstXp;
                        nextCtrl.memToReg = wbIrqLink;
                        nextCtrl.pcSrc = pcIrq;
                end else if (!selLegal) begin
                        nextCtrl = '0; // kernel mode no-op
                        if (!kernelMode) begin
                                nextCtrl.regWr = 1'b1;
                                nextCtrl.regDst = dstXp;
                                nextCtrl.memToReg = wbLink;
                                nextCtrl.pcSrc = pcExc;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        ctrl <= '0;
                        ctrlValid <= 1'b0;
                end else begin
                        ctrlValid <= instrValid;
                        if (instrValid) begin
                                ctrl <= nextCtrl; // hold on bubble
                        end
                end
        end

        // no decoded instruction may both load and store
        memExclusive: assert property (
                @(posedge clk) disable iff (rst)
                ctrlValid |-> !(ctrl.memWr && ctrl.memRd)
        ) else $error("memWr and memRd both set on a valid bundle");

        resetClearsValid: assert property (
                @(posedge clk) rst |=> !ctrlValid
        ) else $error("ctrlValid high in the cycle after reset");

endmodule

// File: verilog/iTypeDecoder.sv
module iTypeDecoder (
        input ctrlPkg::instrWord instr,
        output ctrlPkg::ctrlBundle ctrl,
        output logic legal
);

        import ctrlPkg::*;

        always_comb begin
                ctrl = '0;
                legal = 1'b1;
                case (instr.iFields.op)
                        6'b100011: begin // lw
                                ctrl.regDst = dstRt;
                                ctrl.regWr = 1'b1;
                                ctrl.aluSrc2 = 1'b1;
                                ctrl.memRd = 1'b1;
                                ctrl.memToReg = wbMem;
                                ctrl.extOp = 1'b1;
                        end
                        6'b101011: begin // sw
                                ctrl.aluSrc2 = 1'b1;
                                ctrl.memWr = 1'b1;
                                ctrl.extOp = 1'b1;
                        end
                        6'b001111: begin // lui
                                ctrl.regDst = dstRt;
                                ctrl.regWr = 1'b1;
                                ctrl.aluSrc2 = 1'b1;
                                ctrl.luOp = 1'b1;
                        end
                        6'b001000: begin // addi
                                ctrl.regDst = dstRt;
                                ctrl.regWr = 1'b1;
                                ctrl.aluSrc2 = 1'b1;
                                ctrl.sign = 1'b1;
                                ctrl.extOp = 1'b1;
                        end
                        6'b001001: begin // addiu
                                ctrl.regDst = dstRt;
                                ctrl.regWr = 1'b1;
                                ctrl.aluSrc2 = 1'b1;
                                ctrl.extOp = 1'b1;
                        end
                        6'b001100: begin // andi, zero extended
                                ctrl.regDst = dstRt;
                                ctrl.regWr = 1'b1;
                                ctrl.aluSrc2 = 1'b1;
                                ctrl.aluFun = aluAnd;
                        end
                        6'b001010: begin // slti
                                ctrl.regDst = dstRt;
                                ctrl.regWr = 1'b1;
                                ctrl.aluSrc2 = 1'b1;
                                ctrl.aluFun = aluLt;
                                ctrl.sign = 1'b1;
                                ctrl.extOp = 1'b1;
                        end
                        6'b001011: begin // sltiu
                                ctrl.regDst = dstRt;
                                ctrl.regWr = 1'b1;
                                ctrl.aluSrc2 = 1'b1;
                                ctrl.aluFun = aluLt;
                                ctrl.extOp = 1'b1;
                        end
                        6'b000100: begin // beq
                                ctrl.pcSrc = pcBranch;
                                ctrl.aluFun = aluEq;
                                ctrl.extOp = 1'b1;
                        end
                        6'b000101: begin // bne
                                ctrl.pcSrc = pcBranch;
                                ctrl.aluFun = aluNeq;
                                ctrl.extOp = 1'b1;
                        end
                        6'b000110: begin // blez
                                ctrl.pcSrc = pcBranch;
                                ctrl.aluFun = aluLez;
                                ctrl.extOp = 1'b1;
                        end
                        6'b000111: begin // bgtz
                                ctrl.pcSrc = pcBranch;
                                ctrl.aluFun = aluGtz;
                                ctrl.extOp = 1'b1;
                        end
                        6'b000001: begin // bltz
                                ctrl.pcSrc = pcBranch;
                                ctrl.aluFun = aluLtz;
                                ctrl.extOp = 1'b1;
                        end
                        6'b000010: begin // j
                                ctrl.pcSrc = pcJump;
                        end
                        6'b000011: begin // jal
                                ctrl.pcSrc = pcJump;
                                ctrl.regWr = 1'b1;
                                ctrl.regDst = dstRa;
                                ctrl.memToReg = wbLink;
                        end
                        default: begin
                                legal = 1'b0; // op zero lands here too
                        end
                endcase
        end

endmodule

// File: verilog/rTypeDecoder.sv
module rTypeDecoder (
        input ctrlPkg::instrWord instr,
        output ctrlPkg::ctrlBundle ctrl,
        output logic legal
);

        import ctrlPkg::*;

        always_comb begin
                ctrl = '0;
                legal = 1'b1;
                case (instr.rFields.funct)
                        6'b100000: begin // add
                                ctrl.regWr = 1'b1;
                                ctrl.sign = 1'b1;
                        end
                        6'b100001: begin // addu
                                ctrl.regWr = 1'b1;
                        end
                        6'b100010: begin // sub
                                ctrl.regWr = 1'b1;
                                ctrl.aluFun = aluSub;
                                ctrl.sign = 1'b1;
                        end
                        6'b100011: begin // subu
                                ctrl.regWr = 1'b1;
                                ctrl.aluFun = aluSub;
                        end
                        6'b100100: begin // and
                                ctrl.regWr = 1'b1;
                                ctrl.aluFun = aluAnd;
                        end
                        6'b100101: begin // or
                                ctrl.regWr = 1'b1;
                                ctrl.aluFun = aluOr;
                        end
                        6'b100110: begin // xor
                                ctrl.regWr = 1'b1;
                                ctrl.aluFun = aluXor;
                        end
                        6'b100111: begin // nor
                                ctrl.regWr = 1'b1;
                                ctrl.aluFun = aluNor;
                        end
                        6'b000000: begin // sll
                                ctrl.regWr = 1'b1;
                                ctrl.aluSrc1 = 1'b1;
                                ctrl.aluFun = aluSll;
                        end
                        6'b000010: begin // srl
                                ctrl.regWr = 1'b1;
                                ctrl.aluSrc1 = 1'b1;
                                ctrl.aluFun = aluSrl;
                        end
                        6'b000011: begin // sra
                                ctrl.regWr = 1'b1;
                                ctrl.aluSrc1 = 1'b1;
                                ctrl.aluFun = aluSra;
                        end
                        6'b101010: begin // slt
                                ctrl.regWr = 1'b1;
                                ctrl.aluFun = aluLt;
                                ctrl.sign = 1'b1;
                        end
                        6'b001000: begin // jr
                                ctrl.pcSrc = pcReg;
                        end
                        6'b001001: begin // jalr
                                ctrl.pcSrc = pcReg;
                                ctrl.regWr = 1'b1;
                                ctrl.regDst = dstRd;
                                ctrl.memToReg = wbLink; // link into rd
                        end
                        default: begin
                                legal = 1'b0; // bundle stays zero
                        end
                endcase
        end

endmodule

// File: verilog/ctrlPkg.sv
`include "control_settings.svh"

package ctrlPkg;

        typedef struct packed {
                logic [`OP_WIDTH-1:0] op;
                logic [`REG_WIDTH-1:0] rs;
                logic [`REG_WIDTH-1:0] rt;
                logic [`REG_WIDTH-1:0] rd;
                logic [`SHAMT_WIDTH-1:0] shamt;
                logic [`FUNCT_WIDTH-1:0] funct;
        } rTypeFields;

        typedef struct packed {
                logic [`OP_WIDTH-1:0] op;
                logic [`REG_WIDTH-1:0] rs;
                logic [`REG_WIDTH-1:0] rt;
                logic [`IMM_WIDTH-1:0] imm16;
        } iTypeFields;

        // same word, register view or immediate view
        typedef union packed {
                rTypeFields rFields;
                iTypeFields iFields;
        } instrWord;

        typedef enum logic [`PCSEL_WIDTH-1:0] {
                pcPlus4 = 3'b000,
                pcBranch = 3'b001,
                pcJump = 3'b010,
                pcReg = 3'b011,
                pcIrq = 3'b100, // interrupt vector
                pcExc = 3'b101 // exception vector
        } pcSel;

        typedef enum logic [`REGDST_WIDTH-1:0] {
                dstRd = 2'b00,
                dstRt = 2'b01,
                dstRa = 2'b10,
                dstXp = 2'b11 // exception pc register
        } regDstSel;

        typedef enum logic [`WBSEL_WIDTH-1:0] {
                wbAlu = 2'b00,
                wbMem = 2'b01,
                wbLink = 2'b10, // pc + 4
                wbIrqLink = 2'b11
        } wbSel;

        typedef enum logic [`ALUFUN_WIDTH-1:0] {
                aluAdd = 6'b000000,
                aluSub = 6'b000001,
                aluAnd = 6'b011000,
                aluOr = 6'b011110,
                aluXor = 6'b010110,
                aluNor = 6'b010001,
                aluSll = 6'b100000,
                aluSrl = 6'b100001,
                aluSra = 6'b100011,
                aluEq = 6'b110011,
                aluNeq = 6'b110001,
                aluLt = 6'b110101,
                aluLez = 6'b111101,
                aluGtz = 6'b111111,
                aluLtz = 6'b111011
        } aluFunCode;

        typedef struct packed {
                pcSel pcSrc;
                regDstSel regDst;
                logic regWr;
                logic aluSrc1; // 1 selects shamt
                logic aluSrc2; // 1 selects immediate
                aluFunCode aluFun;
                logic sign;
                logic memWr;
                logic memRd;
                wbSel memToReg;
                logic extOp; // sign extend imm
                logic luOp;
        } ctrlBundle;

endpackage

// File: verilog/control_settings.svh
`ifndef CONTROL_SETTINGS_SVH
`define CONTROL_SETTINGS_SVH

// instruction word layout
`define INSTR_WIDTH 32
`define OP_WIDTH 6
`define REG_WIDTH 5
`define SHAMT_WIDTH 5
`define FUNCT_WIDTH 6
`define IMM_WIDTH (`INSTR_WIDTH - `OP_WIDTH - 2 * `REG_WIDTH)

// control bundle fields
`define ALUFUN_WIDTH 6
`define PCSEL_WIDTH 3
`define REGDST_WIDTH 2
`define WBSEL_WIDTH 2

`endif
